//--- tb.f
mips_isa_pkg.sv
mips_ctrl_pkg.sv
alu.sv
regfile.sv
mult_unit.sv
datapath.sv
controller.sv
mips_core.sv
tb_mips_core.sv

//--- run.sh
#!/bin/sh
# Compile and run the MIPS core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_mips_core -f tb.f -o sim_tb_mips_core
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb_mips_core
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation returned status $status"
  exit $status
fi
exit 0

//--- tb_mips_core.sv
`timescale 1ns/1ps

module tb_mips_core
  import mips_isa_pkg::*;
();

  localparam int    clk_period  = 40;
  localparam int    test_budget = 40;
  localparam int    n_tests     = 6;
  localparam word_t boot_pc     = '0;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      pc_stall = 1'b0;
  word_t     instr = '0;
  word_t     read_data = '0;
  reg_addr_t debug_addr;
  word_t     pc;
  word_t     alu_out;
  word_t     write_data;
  word_t     debug_data;
  logic      mem_write;

  instr_u imem [64];
  word_t  dmem [64];
  word_t  exp_addr [$];
  word_t  exp_data [$];
  word_t  lfsr_state = 32'hbd09;
  word_t  prev_pc = '0;
  int     same_cnt = 0;
  logic   stall_on = 1'b0;

  mips_core #(
    .reset_pc (boot_pc)
  ) u_mips_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc_stall   (pc_stall),
    .instr      (instr),
    .read_data  (read_data),
    .debug_addr (debug_addr),
    .pc         (pc),
    .alu_out    (alu_out),
    .write_data (write_data),
    .debug_data (debug_data),
    .mem_write  (mem_write)
  );

  initial begin
    forever #(clk_period / 2) clk = ~clk;
  end

  // Memory models driven at the falling edge
  always @(negedge clk) begin
    if (pc_stall) check_word(pc, prev_pc, "pc");
    same_cnt = (pc == prev_pc) ? same_cnt + 1 : 0;
    prev_pc  = pc;
    instr    = imem[pc[7:2]];
    // Stall test holds the sw at 4 and the addi at 8 for three cycles each
    pc_stall = stall_on && (pc == 32'd4 || pc == 32'd8) && same_cnt < 3;
    #1;
    read_data = dmem[alu_out[7:2]];
    if (pc_stall) check_bit(mem_write, 1'b0, "mem_write");
  end

  // Each store must match the next expected address and data
  always @(posedge clk) begin
    if (rst_n && mem_write) begin
      if (exp_addr.size() == 0) begin
        abort_run($sformatf("Unexpected store to %h at %0t", alu_out, $time));
      end else begin
        check_word(alu_out, exp_addr.pop_front(), "alu_out");
        check_word(write_data, exp_data.pop_front(), "write_data");
        dmem[alu_out[7:2]] = write_data;
      end
    end
  end

  initial begin
    #(2 * n_tests * test_budget * clk_period);
    $display("Watchdog expired before the tests finished");
    $display("Test failed");
    $fatal(1);
  end

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic word_t rand_bits(int n);
    word_t r;
    logic  fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic word_t sext(logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic instr_u asm_r(logic [5:0] fn, int rd, int rs, int rt);
    instr_u w;
    w.r_fmt = '{op_rtype, reg_addr_t'(rs), reg_addr_t'(rt), reg_addr_t'(rd), 5'd0, fn};
    return w;
  endfunction

  function automatic instr_u asm_i(logic [5:0] op, int rt, int rs, logic [15:0] imm);
    instr_u w;
    w.i_fmt = '{op, reg_addr_t'(rs), reg_addr_t'(rt), imm};
    return w;
  endfunction

  function automatic instr_u asm_j(logic [5:0] op, int target);
    instr_u w;
    w.j_fmt = '{op, 26'(target)};
    return w;
  endfunction

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_word(word_t act, word_t exp, string name);
    if (act !== exp) begin
      $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_bit(logic act, logic exp, string name);
    if (act !== exp) begin
      $display("CHECK FAILED time=%0t %s expected=%b actual=%b", $time, name, exp, act);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_reg(int r, word_t exp);
    @(negedge clk);
    debug_addr = reg_addr_t'(r);
    #1;
    check_word(debug_data, exp, $sformatf("r%0d", r));
  endtask

  // Hold the core in reset while the program is replaced
  task automatic clear_program();
    rst_n = 1'b0;
    for (int i = 0; i < 64; i++) begin
      imem[i] = '0;
    end
  endtask

  task automatic reset_core();
    rst_n = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic run_until(word_t halt);
    int n;
    n = 0;
    while (pc !== halt && n < test_budget) begin
      @(negedge clk);
      n++;
    end
    if (pc !== halt) begin
      abort_run($sformatf("Program did not reach halt address %h in %0d cycles", halt, n));
    end
  endtask

  task automatic test_reset();
    clear_program();
    imem[0] = asm_i(op_addi, 1, 0, 16'd1);
    imem[1] = asm_i(op_addi, 15, 0, 16'd1);
    imem[2] = asm_j(op_jal, 3);
    imem[3] = asm_j(op_j, 3);
    reset_core();
    run_until(32'd12);
    // Reset again while pc and registers hold nonzero values
    clear_program();
    imem[0] = asm_j(op_j, 0);
    reset_core();
    check_word(pc, boot_pc, "pc");
    check_bit(mem_write, 1'b0, "mem_write");
    check_reg(1, '0);
    check_reg(15, '0);
    check_reg(31, '0);
  endtask

  task automatic test_arith();
    logic [15:0] ia;
    logic [15:0] ib;
    word_t       m [8];
    ia = 16'(rand_bits(16));
    ib = 16'(rand_bits(16));
    m[0] = '0;
    m[1] = sext(ia);
    m[2] = sext(ib);
    m[3] = m[1] + m[2];
    m[4] = m[1] - m[2];
    m[5] = m[1] & m[2];
    m[6] = m[1] | m[2];
    m[7] = ($signed(m[1]) < $signed(m[2])) ? 32'd1 : 32'd0;
    clear_program();
    imem[0] = asm_i(op_addi, 1, 0, ia);
    imem[1] = asm_i(op_addi, 2, 0, ib);
    imem[2] = asm_r(fn_add, 3, 1, 2);
    imem[3] = asm_r(fn_sub, 4, 1, 2);
    imem[4] = asm_r(fn_and, 5, 1, 2);
    imem[5] = asm_r(fn_or, 6, 1, 2);
    imem[6] = asm_r(fn_slt, 7, 1, 2);
    // Write to r0 must be dropped
    imem[7] = asm_r(fn_add, 0, 1, 2);
    imem[8] = asm_j(op_j, 8);
    reset_core();
    run_until(32'd32);
    for (int r = 0; r < 8; r++) begin
      check_reg(r, m[r]);
    end
  endtask

  task automatic test_memory();
    logic [15:0] va;
    logic [15:0] vb;
    va = 16'(rand_bits(16));
    vb = 16'(rand_bits(16));
    clear_program();
    imem[0] = asm_i(op_addi, 1, 0, va);
    imem[1] = asm_i(op_addi, 2, 0, vb);
    imem[2] = asm_i(op_addi, 3, 0, 16'd24);
    imem[3] = asm_i(op_sw, 1, 3, 16'd0);
    imem[4] = asm_i(op_sw, 2, 3, 16'd8);
    imem[5] = asm_i(op_lw, 4, 3, 16'd0);
    imem[6] = asm_i(op_lw, 5, 3, 16'd8);
    imem[7] = asm_j(op_j, 7);
    exp_addr.push_back(32'd24);
    exp_data.push_back(sext(va));
    exp_addr.push_back(32'd32);
    exp_data.push_back(sext(vb));
    reset_core();
    run_until(32'd28);
    check_word(word_t'(exp_addr.size()), '0, "pending stores");
    check_reg(4, sext(va));
    check_reg(5, sext(vb));
  endtask

  task automatic test_control();
    word_t exp_pc [8];
    // Taken beq lands on pc+4 plus imm*4 and jal stays in region 0 of pc+4
    exp_pc = '{32'd0, 32'd4, 32'd8, 32'd12 + (32'd2 << 2), 32'd24,
               {4'h0, 26'd10, 2'b00}, 32'd24 + 32'd4, {4'h0, 26'd7, 2'b00}};
    clear_program();
    imem[0]  = asm_i(op_addi, 1, 0, 16'd7);
    imem[1]  = asm_i(op_addi, 2, 0, 16'd7);
    imem[2]  = asm_i(op_beq, 2, 1, 16'd2);
    imem[3]  = asm_i(op_addi, 9, 0, 16'd1);
    imem[4]  = asm_i(op_addi, 9, 0, 16'd1);
    imem[5]  = asm_i(op_beq, 0, 1, 16'd5);
    imem[6]  = asm_j(op_jal, 10);
    imem[7]  = asm_j(op_j, 7);
    imem[10] = asm_r(fn_jr, 0, 31, 0);
    reset_core();
    check_word(pc, exp_pc[0], "pc");
    for (int i = 1; i < 8; i++) begin
      @(negedge clk);
      check_word(pc, exp_pc[i], "pc");
    end
    check_reg(31, 32'd28);
    check_reg(9, '0);
  endtask

  task automatic test_mult();
    logic [15:0]        a;
    logic [15:0]        b;
    logic [15:0]        c;
    word_t              x;
    logic signed [63:0] p;
    a = 16'(rand_bits(16));
    b = 16'(rand_bits(16));
    c = 16'(rand_bits(16));
    p = $signed({{48{a[15]}}, a}) * $signed({{48{b[15]}}, b});
    x = p[31:0];
    p = $signed({{32{x[31]}}, x}) * $signed({{48{c[15]}}, c});
    clear_program();
    imem[0] = asm_i(op_addi, 1, 0, a);
    imem[1] = asm_i(op_addi, 2, 0, b);
    imem[2] = asm_r(fn_mult, 0, 1, 2);
    imem[3] = asm_r(fn_mflo, 3, 0, 0);
    imem[4] = asm_i(op_addi, 4, 0, c);
    imem[5] = asm_r(fn_mult, 0, 3, 4);
    imem[6] = asm_r(fn_mfhi, 5, 0, 0);
    imem[7] = asm_r(fn_mflo, 6, 0, 0);
    imem[8] = asm_j(op_j, 8);
    reset_core();
    run_until(32'd32);
    check_reg(3, x);
    check_reg(5, p[63:32]);
    check_reg(6, p[31:0]);
  endtask

  task automatic test_stall();
    logic [15:0] v;
    v = 16'(rand_bits(16));
    clear_program();
    imem[0] = asm_i(op_addi, 1, 0, v);
    imem[1] = asm_i(op_sw, 1, 0, 16'd40);
    imem[2] = asm_i(op_addi, 1, 1, 16'd1);
    imem[3] = asm_j(op_j, 3);
    exp_addr.push_back(32'd40);
    exp_data.push_back(sext(v));
    stall_on = 1'b1;
    reset_core();
    run_until(32'd12);
    stall_on = 1'b0;
    check_word(word_t'(exp_addr.size()), '0, "pending stores");
    check_word(dmem[10], sext(v), "dmem[10]");
    check_reg(1, sext(v) + 32'd1);
  endtask

  initial begin
    rst_n      = 1'b0;
    debug_addr = '0;
    test_reset();
    test_arith();
    test_memory();
    test_control();
    test_mult();
    test_stall();
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- mips_core.sv
`timescale 1ns/1ps

module mips_core
  import mips_isa_pkg::*, mips_ctrl_pkg::*;
#(
  parameter word_t reset_pc = '0
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      pc_stall,
  input  word_t     instr,
  input  word_t     read_data,
  input  reg_addr_t debug_addr,
  output word_t     pc,
  output word_t     alu_out,
  output word_t     write_data,
  output word_t     debug_data,
  output logic      mem_write
);

  logic    pc_en;
  pc_sel_t pc_sel;
  logic    reg_write;
  logic    reg_dst;
  logic    link;
  logic    alu_src;
  alu_op_t alu_ctrl;
  logic    mem_to_reg;
  logic    mult_write;
  logic    hilo_rd;
  logic    hilo_hi;
  logic    zero;

  controller u_controller (
    .instr      (instr),
    .zero       (zero),
    .pc_stall   (pc_stall),
    .pc_en      (pc_en),
    .pc_sel     (pc_sel),
    .reg_write  (reg_write),
    .reg_dst    (reg_dst),
    .link       (link),
    .alu_src    (alu_src),
    .alu_ctrl   (alu_ctrl),
    .mem_to_reg (mem_to_reg),
    .mult_write (mult_write),
    .hilo_rd    (hilo_rd),
    .hilo_hi    (hilo_hi),
    .mem_write  (mem_write)
  );

  datapath #(
    .reset_pc (reset_pc)
  ) u_datapath (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc_en      (pc_en),
    .pc_sel     (pc_sel),
    .reg_write  (reg_write),
    .reg_dst    (reg_dst),
    .link       (link),
    .alu_src    (alu_src),
    .alu_ctrl   (alu_ctrl),
    .mem_to_reg (mem_to_reg),
    .mult_write (mult_write),
    .hilo_rd    (hilo_rd),
    .hilo_hi    (hilo_hi),
    .instr      (instr),
    .read_data  (read_data),
    .debug_addr (debug_addr),
    .zero       (zero),
    .pc         (pc),
    .alu_out    (alu_out),
    .write_data (write_data),
    .debug_data (debug_data)
  );

endmodule

//--- controller.sv
`timescale 1ns/1ps

module controller
  import mips_isa_pkg::*, mips_ctrl_pkg::*;
(
  input  instr_u  instr,
  input  logic    zero,
  input  logic    pc_stall,
  output logic    pc_en,
  output pc_sel_t pc_sel,
  output logic    reg_write,
  output logic    reg_dst,
  output logic    link,
  output logic    alu_src,
  output alu_op_t alu_ctrl,
  output logic    mem_to_reg,
  output logic    mult_write,
  output logic    hilo_rd,
  output logic    hilo_hi,
  output logic    mem_write
);

  logic jump;
  logic jump_reg;
  logic branch;
  logic reg_write_d;
  logic mult_write_d;
  logic mem_write_d;

  always_comb begin
    jump         = 1'b0;
    jump_reg     = 1'b0;
    branch       = 1'b0;
    reg_write_d  = 1'b0;
    mult_write_d = 1'b0;
    mem_write_d  = 1'b0;
    reg_dst      = 1'b0;
    link         = 1'b0;
    alu_src      = 1'b0;
    alu_ctrl     = alu_add;
    mem_to_reg   = 1'b0;
    hilo_rd      = 1'b0;
    hilo_hi      = 1'b0;

    unique case (instr.r_fmt.opcode)
      op_rtype: begin
        reg_dst = 1'b1;
        unique case (instr.r_fmt.funct)
          fn_add: begin
            reg_write_d = 1'b1;
            alu_ctrl    = alu_add;
          end
          fn_sub: begin
            reg_write_d = 1'b1;
            alu_ctrl    = alu_sub;
          end
          fn_and: begin
            reg_write_d = 1'b1;
            alu_ctrl    = alu_and;
          end
          fn_or: begin
            reg_write_d = 1'b1;
            alu_ctrl    = alu_or;
          end
          fn_slt: begin
            reg_write_d = 1'b1;
            alu_ctrl    = alu_slt;
          end
          fn_jr:   jump_reg = 1'b1;
          fn_mult: mult_write_d = 1'b1;
          fn_mfhi: begin
            reg_write_d = 1'b1;
            hilo_rd     = 1'b1;
            hilo_hi     = 1'b1;
          end
          fn_mflo: begin
            reg_write_d = 1'b1;
            hilo_rd     = 1'b1;
          end
          default: ;
        endcase
      end
      op_lw: begin
        reg_write_d = 1'b1;
        alu_src     = 1'b1;
        mem_to_reg  = 1'b1;
      end
      op_sw: begin
        mem_write_d = 1'b1;
        alu_src     = 1'b1;
      end
      op_beq: begin
        branch   = 1'b1;
        alu_ctrl = alu_sub;
      end
      op_addi: begin
        reg_write_d = 1'b1;
        alu_src     = 1'b1;
      end
      op_j:    jump = 1'b1;
      op_jal: begin
        jump        = 1'b1;
        link        = 1'b1;
        reg_write_d = 1'b1;
      end
      // Unsupported encodings leave every write off
      default: ;
    endcase
  end

  // beq is taken only on equal operands
  assign pc_sel = jump              ? pc_jump   :
                  jump_reg          ? pc_reg    :
                  (branch && zero)  ? pc_branch : pc_plus4;

  // A stall freezes every state update for this instruction
  assign pc_en      = !pc_stall;
  assign reg_write  = reg_write_d  && !pc_stall;
  assign mult_write = mult_write_d && !pc_stall;
  assign mem_write  = mem_write_d  && !pc_stall;

endmodule

//--- datapath.sv
`timescale 1ns/1ps

module datapath
  import mips_isa_pkg::*, mips_ctrl_pkg::*;
#(
  parameter word_t reset_pc = '0
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      pc_en,
  input  pc_sel_t   pc_sel,
  input  logic      reg_write,
  input  logic      reg_dst,
  input  logic      link,
  input  logic      alu_src,
  input  alu_op_t   alu_ctrl,
  input  logic      mem_to_reg,
  input  logic      mult_write,
  input  logic      hilo_rd,
  input  logic      hilo_hi,
  input  instr_u    instr,
  input  word_t     read_data,
  input  reg_addr_t debug_addr,
  output logic      zero,
  output word_t     pc,
  output word_t     alu_out,
  output word_t     write_data,
  output word_t     debug_data
);

  word_t     pc_next;
  word_t     pc_plus4;
  word_t     pc_jump_tgt;
  word_t     pc_branch_tgt;
  word_t     imm_ext;
  word_t     src_a;
  word_t     src_b;
  word_t     alu_y;
  word_t     hi;
  word_t     lo;
  word_t     result;
  word_t     wb_data;
  reg_addr_t wb_addr;

  // Program counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else if (pc_en) begin
      pc <= pc_next;
    end
  end

  assign imm_ext       = {{(data_w-16){instr.i_fmt.imm[15]}}, instr.i_fmt.imm};
  assign pc_plus4      = pc + word_t'(4);
  assign pc_branch_tgt = pc_plus4 + (imm_ext << 2);
  // Jump stays inside the current 256 MB region
  assign pc_jump_tgt   = {pc_plus4[31:28], instr.j_fmt.target, 2'b00};

  always_comb begin
    unique case (pc_sel)
      pc_jump:   pc_next = pc_jump_tgt;
      pc_branch: pc_next = pc_branch_tgt;
      pc_reg:    pc_next = src_a;
      default:   pc_next = pc_plus4;
    endcase
  end

  // jal overrides the destination with the link register
  assign wb_addr = link    ? reg_ra :
                   reg_dst ? instr.r_fmt.rd : instr.r_fmt.rt;

  regfile u_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .we         (reg_write),
    .ra1        (instr.r_fmt.rs),
    .ra2        (instr.r_fmt.rt),
    .wa         (wb_addr),
    .debug_addr (debug_addr),
    .wd         (wb_data),
    .rd1        (src_a),
    .rd2        (write_data),
    .debug_data (debug_data)
  );

  assign src_b = alu_src ? imm_ext : write_data;

  alu u_alu (
    .a    (src_a),
    .b    (src_b),
    .op   (alu_ctrl),
    .y    (alu_y),
    .zero (zero)
  );

  mult_unit u_mult_unit (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (mult_write),
    .a     (src_a),
    .b     (write_data),
    .hi    (hi),
    .lo    (lo)
  );

  // mfhi and mflo route hi/lo onto the ALU result path
  assign alu_out = hilo_rd ? (hilo_hi ? hi : lo) : alu_y;

  // Write-back selection
  assign result  = mem_to_reg ? read_data : alu_out;
  assign wb_data = link ? pc_plus4 : result;

endmodule

//--- mult_unit.sv
`timescale 1ns/1ps

module mult_unit
  import mips_isa_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  we,
  input  word_t a,
  input  word_t b,
  output word_t hi,
  output word_t lo
);

  logic signed [2*data_w-1:0] product;

  assign product = $signed(a) * $signed(b);

  // Upper half to hi, lower half to lo
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hi <= '0;
      lo <= '0;
    end else if (we) begin
      hi <= product[2*data_w-1:data_w];
      lo <= product[data_w-1:0];
    end
  end

  a_operands_known: assert property (@(posedge clk) disable iff (!rst_n)
    we |-> !$isunknown({a, b}));

endmodule

//--- regfile.sv
`timescale 1ns/1ps

module regfile
  import mips_isa_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      we,
  input  reg_addr_t ra1,
  input  reg_addr_t ra2,
  input  reg_addr_t wa,
  input  reg_addr_t debug_addr,
  input  word_t     wd,
  output word_t     rd1,
  output word_t     rd2,
  output word_t     debug_data
);

  word_t regs [32];

  // Register 0 is never written, so it keeps its reset value of zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != '0)) begin
      regs[wa] <= wd;
    end
  end

  // Reads see the old value during a write cycle
  assign rd1        = regs[ra1];
  assign rd2        = regs[ra2];
  assign debug_data = regs[debug_addr];

  a_write_known: assert property (@(posedge clk) disable iff (!rst_n)
    we |-> !$isunknown({wa, wd}));

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu
  import mips_isa_pkg::*, mips_ctrl_pkg::*;
(
  input  word_t   a,
  input  word_t   b,
  input  alu_op_t op,
  output word_t   y,
  output logic    zero
);

  logic lt;

  // Signed compare for slt
  assign lt = $signed(a) < $signed(b);

  always_comb begin
    unique case (op)
      alu_and: y = a & b;
      alu_or:  y = a | b;
      alu_add: y = a + b;
      alu_sub: y = a - b;
      alu_slt: y = {{(data_w-1){1'b0}}, lt};
      default: y = '0;
    endcase
  end

  // beq compares through a subtract, so zero means equal
  assign zero = (y == '0);

endmodule

//--- mips_ctrl_pkg.sv
package mips_ctrl_pkg;

  // ALU operation, classic MIPS 3-bit control encoding
  typedef enum logic [2:0] {
    alu_and = 3'b000,
    alu_or  = 3'b001,
    alu_add = 3'b010,
    alu_sub = 3'b110,
    alu_slt = 3'b111
  } alu_op_t;

  // Next-PC source
  typedef enum logic [1:0] {
    pc_plus4  = 2'd0,
    pc_jump   = 2'd1,
    pc_branch = 2'd2,
    pc_reg    = 2'd3
  } pc_sel_t;

endpackage

//--- mips_isa_pkg.sv
package mips_isa_pkg;

  // Word width is fixed by the MIPS field layout
  localparam int data_w = 32;

  typedef logic [data_w-1:0] word_t;
  typedef logic [4:0]        reg_addr_t;

  // Register format: opcode, rs, rt, rd, shamt, funct
  typedef struct packed {
    logic [5:0] opcode;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fmt_t;

  // Immediate format, used by addi, lw, sw and beq
  typedef struct packed {
    logic [5:0]  opcode;
    reg_addr_t   rs;
    reg_addr_t   rt;
    logic [15:0] imm;
  } i_fmt_t;

  // Jump format with a 26-bit word target
  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;
  } j_fmt_t;

  // One instruction word seen through its three formats
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    j_fmt_t j_fmt;
  } instr_u;

  // Opcodes
  localparam logic [5:0] op_rtype = 6'h00;
  localparam logic [5:0] op_j     = 6'h02;
  localparam logic [5:0] op_jal   = 6'h03;
  localparam logic [5:0] op_beq   = 6'h04;
  localparam logic [5:0] op_addi  = 6'h08;
  localparam logic [5:0] op_lw    = 6'h23;
  localparam logic [5:0] op_sw    = 6'h2b;

  // Funct codes for R-type
  localparam logic [5:0] fn_jr    = 6'h08;
  localparam logic [5:0] fn_mfhi  = 6'h10;
  localparam logic [5:0] fn_mflo  = 6'h12;
  localparam logic [5:0] fn_mult  = 6'h18;
  localparam logic [5:0] fn_add   = 6'h20;
  localparam logic [5:0] fn_sub   = 6'h22;
  localparam logic [5:0] fn_and   = 6'h24;
  localparam logic [5:0] fn_or    = 6'h25;
  localparam logic [5:0] fn_slt   = 6'h2a;

  // Link register written by jal
  localparam reg_addr_t reg_ra = 5'd31;

endpackage
